// File: build.f
logic/obj_pkg.sv
logic/obj_entry_if.sv
logic/obj_slice_if.sv
logic/obj_line_scan.sv
logic/obj_tile_fetch.sv
logic/obj_line_draw.sv
logic/obj_engine.sv
verification/obj_engine_sva.sv
verification/obj_engine_tb.sv

// File: logic/obj_engine.sv
`timescale 1ns/10ps
// vrender and scroll must hold from line_start_i until line_done_o
module obj_engine (
    input  logic                            clk96_i,
    input  logic                            reset96_i,
    input  logic                            line_start_i,
    input  logic [obj_pkg::POS_W-2:0]       vrender_i,
    input  logic [obj_pkg::POS_W-2:0]       scroll_x_i,
    input  logic [obj_pkg::POS_W-2:0]       scroll_y_i,
    output logic [obj_pkg::SRAM_AW-1:0]     sram_addr_a_o,
    input  logic [obj_pkg::SRAM_DW-1:0]     sram_dout_a_i,
    output logic [obj_pkg::SRAM_AW-1:0]     sram_addr_b_o,
    input  logic [obj_pkg::SRAM_DW-1:0]     sram_dout_b_i,
    output logic                            gfx_cs_o,
    input  logic                            gfx_ok_i,
    output logic [obj_pkg::TILE_W-1:0]      gfx_tile_o,
    output logic [obj_pkg::GFX_OFFS_W-1:0]  gfx_offs_o,
    input  logic [obj_pkg::GFX_DW-1:0]      gfx_data_i,
    output logic                            line_done_o,
    input  logic [obj_pkg::POS_W-2:0]       pix_addr_i,
    output logic [obj_pkg::OBJ_PIXEL_W-1:0] obj_pixel_o
);
    obj_entry_if u_entry_if ();
    obj_slice_if u_slice_if ();

    obj_line_scan u_scan (
        .clk96_i       (clk96_i),
        .reset96_i     (reset96_i),
        .line_start_i  (line_start_i),
        .vrender_i     (vrender_i),
        .scroll_x_i    (scroll_x_i),
        .scroll_y_i    (scroll_y_i),
        .sram_dout_a_i (sram_dout_a_i),
        .sram_dout_b_i (sram_dout_b_i),
        .sram_addr_a_o (sram_addr_a_o),
        .sram_addr_b_o (sram_addr_b_o),
        .ent           (u_entry_if.scan_mp)
    );

    obj_tile_fetch u_fetch (
        .clk96_i      (clk96_i),
        .reset96_i    (reset96_i),
        .line_start_i (line_start_i),
        .gfx_ok_i     (gfx_ok_i),
        .gfx_data_i   (gfx_data_i),
        .gfx_cs_o     (gfx_cs_o),
        .gfx_tile_o   (gfx_tile_o),
        .gfx_offs_o   (gfx_offs_o),
        .line_done_o  (line_done_o),
        .ent          (u_entry_if.fetch_mp),
        .slc          (u_slice_if.fetch_mp)
    );

    obj_line_draw u_draw (
        .clk96_i      (clk96_i),
        .reset96_i    (reset96_i),
        .line_start_i (line_start_i),
        .pix_addr_i   (pix_addr_i),
        .obj_pixel_o  (obj_pixel_o),
        .slc          (u_slice_if.draw_mp)
    );
endmodule

// File: logic/obj_entry_if.sv
`timescale 1ns/10ps
// one record in flight, fetch raises next again only after entry_valid or line_end
interface obj_entry_if;
    import obj_pkg::*;

    logic                    next;        // fetch asks for the following record
    logic                    entry_valid;
    logic                    line_end;    // every queue drained
    logic [ATTR_W-1:0]       attr;
    logic signed [POS_W-1:0] x;           // scroll applied and wrapped
    logic [ROW_W-1:0]        row;         // line inside the sprite

    modport scan_mp (
        input  next,
        output entry_valid, line_end, attr, x, row
    );

    modport fetch_mp (
        output next,
        input  entry_valid, line_end, attr, x, row
    );
endinterface

// File: logic/obj_line_draw.sv
`timescale 1ns/10ps
// readout is valid between line_done and the next line start, and reads zero while clearing
module obj_line_draw (
    input  logic                            clk96_i,
    input  logic                            reset96_i,
    input  logic                            line_start_i,
    input  logic [obj_pkg::POS_W-2:0]       pix_addr_i,
    output logic [obj_pkg::OBJ_PIXEL_W-1:0] obj_pixel_o,
    obj_slice_if.draw_mp                    slc
);
    import obj_pkg::*;

    localparam int K_W = $clog2(SLICE_PIX);

    logic [OBJ_PIXEL_W-1:0]  lbuf [SCREEN_W];
    logic                    clr_busy;
    logic [POS_W-2:0]        clr_addr;
    logic                    drawing;
    logic [K_W-1:0]          k;
    logic [GFX_DW-1:0]       s_data;
    logic signed [POS_W-1:0] s_xbase;
    logic                    s_xflip;
    logic [PRI_W+PAL_W-1:0]  s_color;
    logic [CODE_W-1:0]       code;
    logic [POS_W-1:0]        pos;
    logic                    we;

    assign code = s_data[{k, 2'b00} +: CODE_W];
    assign pos  = s_xbase + POS_W'(s_xflip ? 3'd7 - k : k);
    // the clear owns the write port, drawing waits for it
    assign we   = clr_busy || (drawing && code != '0 && !pos[POS_W-1]
                               && pos[POS_W-2:0] < SCREEN_W);
    assign slc.slice_done = drawing && !clr_busy && k == K_W'(SLICE_PIX - 1);

    always_ff @(posedge clk96_i) begin
        if (we) lbuf[clr_busy ? clr_addr : pos[POS_W-2:0]] <= clr_busy ? '0 : {s_color, code};
        if (slc.slice_valid) begin
            s_data  <= slc.data;
            s_xbase <= slc.x_base;
            s_xflip <= slc.xflip;
            s_color <= slc.color;
        end
    end

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            clr_busy    <= 1'b1;  // wipe the buffer once after reset
            clr_addr    <= '0;
            drawing     <= 1'b0;
            k           <= '0;
            obj_pixel_o <= '0;
        end else begin
            if (clr_busy) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == (POS_W-1)'(SCREEN_W - 1)) clr_busy <= 1'b0;
            end
            if (line_start_i && !slc.active) begin
                clr_busy <= 1'b1;
                clr_addr <= '0;
            end
            if (slc.slice_valid) begin
                drawing <= 1'b1;
                k       <= '0;
            end else if (drawing && !clr_busy) begin
                k <= k + 1'b1;
                if (k == K_W'(SLICE_PIX - 1)) drawing <= 1'b0;
            end
            obj_pixel_o <= (clr_busy || pix_addr_i >= SCREEN_W) ? '0 : lbuf[pix_addr_i];
        end
    end
endmodule

// File: logic/obj_line_scan.sv
`timescale 1ns/10ps
// sprite RAM ports need exactly one cycle of read latency
// three cycles per table entry, entry_valid follows next by four cycles
module obj_line_scan (
    input  logic                        clk96_i,
    input  logic                        reset96_i,
    input  logic                        line_start_i,
    input  logic [obj_pkg::POS_W-2:0]   vrender_i,
    input  logic [obj_pkg::POS_W-2:0]   scroll_x_i,
    input  logic [obj_pkg::POS_W-2:0]   scroll_y_i,
    input  logic [obj_pkg::SRAM_DW-1:0] sram_dout_a_i,
    input  logic [obj_pkg::SRAM_DW-1:0] sram_dout_b_i,
    output logic [obj_pkg::SRAM_AW-1:0] sram_addr_a_o,
    output logic [obj_pkg::SRAM_AW-1:0] sram_addr_b_o,
    obj_entry_if.scan_mp                ent
);
    import obj_pkg::*;

    localparam int W0_OFS = ATTR_W - SRAM_DW;  // word 0 is the record top
    localparam int IDX_W  = $clog2(NUM_SPRITES);
    localparam int CNT_W  = IDX_W + 1;
    localparam int PIDX_W = $clog2(NUM_PRI);

    typedef enum logic [2:0] {
        S_IDLE, S_SCAN, S_SERVE, S_QRD, S_ADDR23, S_W01, S_OUT, S_END
    } state_t;

    state_t                          state;
    logic [1:0]                      phase;
    logic [IDX_W-1:0]                scan_idx;
    logic [IDX_W-1:0]                rd_idx;     // position inside the current queue
    logic [NUM_PRI-1:0]              occupied;
    logic [NUM_PRI-1:0][CNT_W-1:0]   cnt;
    logic                            next_pend;  // next seen while still scanning
    logic [PIDX_W-1:0]               lo_pri;
    logic [PIDX_W-1:0]               scan_pri;
    logic                            q_we;
    logic [IDX_W-1:0]                qmem [NUM_PRI*NUM_SPRITES];
    logic [IDX_W-1:0]                q_dout;
    logic [SRAM_DW-1:0]              w0_q, w1_q;
    logic [ATTR_W-1:0]               rec;
    logic signed [POS_W-1:0]         y_pos;
    logic [POS_W:0]                  y_diff;
    logic [ROW_W:0]                  y_height;
    logic                            y_hit;

    // raw position plus scroll, mod 512, then wrap into negative range
    function automatic logic signed [POS_W-1:0] wrap_pos(input logic [POS_W-2:0] raw,
                                                         input logic [POS_W-2:0] scroll);
        logic [POS_W-2:0] sum;
        sum = raw + scroll;
        wrap_pos = (sum > WRAP_LIMIT) ? {1'b1, sum} : {1'b0, sum};
    endfunction

    // word 3 is on port b both while scanning and while serving
    always_comb begin
        y_pos    = wrap_pos(sram_dout_b_i[ATTR_YPOS_LSB +: POS_W-1], scroll_y_i);
        y_height = ({1'b0, sram_dout_b_i[ATTR_YSIZE_LSB +: SIZE_W]} + 1'b1) << 3;
        y_diff   = {2'b00, vrender_i} - {y_pos[POS_W-1], y_pos};
        y_hit    = !y_diff[POS_W] && (y_diff[POS_W-1:0] < y_height);
    end

    assign scan_pri = sram_dout_a_i[ATTR_PRI_LSB - W0_OFS +: PRI_W];
    assign q_we     = (state == S_SCAN) && (phase == 2'd2) && y_hit
                      && sram_dout_a_i[ATTR_ACTIVE - W0_OFS];

    always_comb begin
        lo_pri = '0;
        for (int p = NUM_PRI - 1; p >= 0; p--) begin
            if (occupied[p]) lo_pri = PIDX_W'(p);
        end
    end

    always_ff @(posedge clk96_i) begin
        if (q_we) qmem[{scan_pri, cnt[scan_pri][IDX_W-1:0]}] <= scan_idx;
        q_dout <= qmem[{lo_pri, rd_idx}];
        if (state == S_W01) begin
            w0_q <= sram_dout_a_i;
            w1_q <= sram_dout_b_i;
        end
    end

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            state         <= S_IDLE;
            phase         <= '0;
            scan_idx      <= '0;
            rd_idx        <= '0;
            occupied      <= '0;
            cnt           <= '0;
            next_pend     <= 1'b0;
            sram_addr_a_o <= '0;
            sram_addr_b_o <= '0;
        end else begin
            if (ent.next) next_pend <= 1'b1;
            case (state)
                S_IDLE: if (line_start_i) begin
                    state     <= S_SCAN;
                    phase     <= '0;
                    scan_idx  <= '0;
                    rd_idx    <= '0;
                    occupied  <= '0;
                    cnt       <= '0;
                    next_pend <= 1'b0;
                end
                S_SCAN: begin
                    phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
                    if (phase == 2'd0) begin
                        sram_addr_a_o <= SRAM_AW'({scan_idx, 2'b00});
                        sram_addr_b_o <= SRAM_AW'({scan_idx, 2'b11}); // word 3
                    end
                    if (phase == 2'd2) begin
                        if (q_we) begin
                            cnt[scan_pri]      <= cnt[scan_pri] + 1'b1;
                            occupied[scan_pri] <= 1'b1;
                        end
                        scan_idx <= scan_idx + 1'b1;
                        if (scan_idx == IDX_W'(NUM_SPRITES - 1)) state <= S_SERVE;
                    end
                end
                S_SERVE: if (ent.next || next_pend) begin
                    next_pend <= 1'b0;
                    if (occupied == '0) begin
                        state <= S_END;
                    end else begin
                        state <= S_QRD;
                        if ({1'b0, rd_idx} + 1'b1 == cnt[lo_pri]) begin
                            occupied[lo_pri] <= 1'b0;  // queue used up
                            rd_idx           <= '0;
                        end else begin
                            rd_idx <= rd_idx + 1'b1;
                        end
                    end
                end
                S_QRD: begin
                    sram_addr_a_o <= SRAM_AW'({q_dout, 2'b00});
                    sram_addr_b_o <= SRAM_AW'({q_dout, 2'b01});
                    state         <= S_ADDR23;
                end
                S_ADDR23: begin
                    sram_addr_a_o <= sram_addr_a_o + 2'd2;
                    sram_addr_b_o <= sram_addr_b_o + 2'd2;
                    state         <= S_W01;
                end
                S_W01:   state <= S_OUT;
                S_OUT:   state <= S_SERVE;
                S_END:   state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // words 2 and 3 come straight from the RAM in S_OUT
    assign rec             = {w0_q, w1_q, sram_dout_a_i, sram_dout_b_i};
    assign ent.attr        = rec;
    assign ent.x           = wrap_pos(rec[ATTR_XPOS_LSB +: POS_W-1], scroll_x_i);
    assign ent.row         = y_diff[ROW_W-1:0];
    assign ent.entry_valid = (state == S_OUT);
    assign ent.line_end    = (state == S_END);
endmodule

// File: logic/obj_pkg.sv
// sizes, record field positions and screen limits for the sprite engine
// a table entry is four 16-bit words, word 0 holds the top bits of the record
package obj_pkg;
    localparam int NUM_SPRITES = 256;
    localparam int NUM_PRI     = 16;
    localparam int SRAM_AW     = 13;
    localparam int SRAM_DW     = 16;
    localparam int ATTR_W      = 64;

    // field positions inside the 64-bit record
    localparam int ATTR_ACTIVE    = 63;
    localparam int ATTR_XFLIP     = 60;
    localparam int ATTR_PRI_LSB   = 56;
    localparam int ATTR_PAL_LSB   = 50;
    localparam int ATTR_TILE_LSB  = 32;
    localparam int ATTR_XPOS_LSB  = 23;
    localparam int ATTR_XSIZE_LSB = 16;
    localparam int ATTR_YPOS_LSB  = 7;
    localparam int ATTR_YSIZE_LSB = 0;

    localparam int PRI_W  = 4;
    localparam int PAL_W  = 6;
    localparam int SIZE_W = 4;      // tile count minus one
    localparam int ROW_W  = 7;      // up to 16 tiles of 8 lines
    localparam int CODE_W = 4;

    localparam int POS_W      = 10;  // signed position after wrap
    localparam int WRAP_LIMIT = 384; // raw positions above this go negative
    localparam int SCREEN_W   = 320;
    localparam int SLICE_PIX  = 8;

    localparam int TILE_W      = 15;
    localparam int GFX_OFFS_W  = 16;
    localparam int GFX_DW      = 32;
    localparam int OBJ_PIXEL_W = 14; // {priority, palette, code}, zero is transparent
endpackage

// File: logic/obj_slice_if.sv
`timescale 1ns/10ps
// one slice in flight, fetch does not send again before slice_done
interface obj_slice_if;
    import obj_pkg::*;

    logic                     active;      // line in progress
    logic                     slice_valid;
    logic [GFX_DW-1:0]        data;
    logic signed [POS_W-1:0]  x_base;
    logic                     xflip;
    logic [PRI_W+PAL_W-1:0]   color;       // priority over palette
    logic                     slice_done;  // eighth pixel written

    modport fetch_mp (
        output active, slice_valid, data, x_base, xflip, color,
        input  slice_done
    );

    modport draw_mp (
        input  active, slice_valid, data, x_base, xflip, color,
        output slice_done
    );
endinterface

// File: logic/obj_tile_fetch.sv
`timescale 1ns/10ps
// request, tile and offset hold until gfx_ok_i; the slice data passes on in that cycle
module obj_tile_fetch (
    input  logic                           clk96_i,
    input  logic                           reset96_i,
    input  logic                           line_start_i,
    input  logic                           gfx_ok_i,
    input  logic [obj_pkg::GFX_DW-1:0]     gfx_data_i,
    output logic                           gfx_cs_o,
    output logic [obj_pkg::TILE_W-1:0]     gfx_tile_o,
    output logic [obj_pkg::GFX_OFFS_W-1:0] gfx_offs_o,
    output logic                           line_done_o,
    obj_entry_if.fetch_mp                  ent,
    obj_slice_if.fetch_mp                  slc
);
    import obj_pkg::*;

    typedef enum logic [2:0] {F_IDLE, F_NEXT, F_WAIT, F_REQ, F_DRAW} state_t;

    state_t                  state;
    logic [SIZE_W-1:0]       col_q;
    logic [SIZE_W-1:0]       tcol;
    logic [SIZE_W-1:0]       xsize_q;
    logic [PRI_W-1:0]        pri_q;
    logic [PAL_W-1:0]        pal_q;
    logic                    xflip_q;
    logic signed [POS_W-1:0] x_q;
    logic [ROW_W-1:0]        row_q;
    logic [GFX_OFFS_W-1:0]   slot;

    // slice index = tile row * tiles across + column, 8 slices per tile
    always_comb begin
        slot = GFX_OFFS_W'(row_q[ROW_W-1:3]) * (GFX_OFFS_W'(xsize_q) + 1'b1)
               + GFX_OFFS_W'(col_q);
        gfx_offs_o = {slot[GFX_OFFS_W-4:0], row_q[2:0]};
    end

    assign tcol = xflip_q ? xsize_q - col_q : col_q;  // flipped sprites start at the far tile

    assign gfx_cs_o        = (state == F_REQ);
    assign ent.next        = (state == F_NEXT);
    assign slc.active      = (state != F_IDLE);
    assign slc.slice_valid = (state == F_REQ) && gfx_ok_i;
    assign slc.data        = gfx_data_i;
    assign slc.x_base      = x_q + POS_W'({tcol, 3'b000});
    assign slc.xflip       = xflip_q;
    assign slc.color       = {pri_q, pal_q};

    always_ff @(posedge clk96_i) begin
        if (state == F_WAIT && ent.entry_valid) begin
            gfx_tile_o <= ent.attr[ATTR_TILE_LSB +: TILE_W];
            pri_q      <= ent.attr[ATTR_PRI_LSB +: PRI_W];
            pal_q      <= ent.attr[ATTR_PAL_LSB +: PAL_W];
            xflip_q    <= ent.attr[ATTR_XFLIP];
            xsize_q    <= ent.attr[ATTR_XSIZE_LSB +: SIZE_W];
            x_q        <= ent.x;
            row_q      <= ent.row;
        end
    end

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            state       <= F_IDLE;
            col_q       <= '0;
            line_done_o <= 1'b0;
        end else begin
            line_done_o <= 1'b0;
            case (state)
                F_IDLE: if (line_start_i) state <= F_NEXT;
                F_NEXT: state <= F_WAIT;
                F_WAIT: begin
                    if (ent.entry_valid) begin
                        col_q <= '0;
                        state <= F_REQ;
                    end else if (ent.line_end) begin
                        line_done_o <= 1'b1;
                        state       <= F_IDLE;
                    end
                end
                F_REQ: if (gfx_ok_i) state <= F_DRAW;  // stall here on slow memory
                F_DRAW: if (slc.slice_done) begin
                    if (col_q == xsize_q) begin
                        state <= F_NEXT;
                    end else begin
                        col_q <= col_q + 1'b1;
                        state <= F_REQ;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end
endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module obj_engine_tb \
    -f build.f \
    --Mdir obj_dir -o obj_engine_sim

./obj_dir/obj_engine_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ok"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// File: verification/obj_engine_sva.sv
`timescale 1ns/10ps
// graphics handshake and line strobe rules, bound into obj_engine
module obj_engine_sva (
    input logic                           clk96_i,
    input logic                           reset96_i,
    input logic                           line_start_i,
    input logic                           line_done_i,
    input logic                           gfx_cs_i,
    input logic                           gfx_ok_i,
    input logic [obj_pkg::TILE_W-1:0]     gfx_tile_i,
    input logic [obj_pkg::GFX_OFFS_W-1:0] gfx_offs_i
);
    int   assert_errs = 0;  // read by the testbench at the end
    logic line_open;        // between line_start and line_done

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) line_open <= 1'b0;
        else if (line_start_i) line_open <= 1'b1;
        else if (line_done_i) line_open <= 1'b0;
    end

    cs_held: assert property (@(posedge clk96_i) disable iff (reset96_i)
        gfx_cs_i && !gfx_ok_i |=> gfx_cs_i)
        else begin
            $error("gfx_cs_o dropped before gfx_ok_i");
            assert_errs++;
        end

    req_stable: assert property (@(posedge clk96_i) disable iff (reset96_i)
        gfx_cs_i && !gfx_ok_i |=> $stable(gfx_tile_i) && $stable(gfx_offs_i))
        else begin
            $error("gfx tile or offset moved while waiting for gfx_ok_i");
            assert_errs++;
        end

    one_done_per_line: assert property (@(posedge clk96_i) disable iff (reset96_i)
        line_done_i |-> line_open)
        else begin
            $error("line_done_o without a line_start_i");
            assert_errs++;
        end
endmodule

bind obj_engine obj_engine_sva u_sva (
    .clk96_i      (clk96_i),
    .reset96_i    (reset96_i),
    .line_start_i (line_start_i),
    .line_done_i  (line_done_o),
    .gfx_cs_i     (gfx_cs_o),
    .gfx_ok_i     (gfx_ok_i),
    .gfx_tile_i   (gfx_tile_o),
    .gfx_offs_i   (gfx_offs_o)
);

// File: verification/obj_engine_tb.sv
`timescale 1ns/10ps
// sprite RAM and graphics memory modelled here, tables random from a fixed seed
// vrender stays below 256, graphics memory covers tile plus offset in 17 bits
module obj_engine_tb;
    import obj_pkg::*;

    localparam int     SRAM_WORDS  = NUM_SPRITES * 4;
    localparam int     GFX_DEPTH   = 1 << 17;
    localparam int     RAND_LINES  = 16;
    localparam int     NUM_LINES   = 5 + RAND_LINES;
    localparam longint LINE_CYCLES = 3 * NUM_SPRITES + 4 * NUM_SPRITES * 16 * 8 + 400;

    logic                   clk96, reset96, line_start;
    logic [POS_W-2:0]       vrender, scroll_x, scroll_y, pix_addr;
    logic [SRAM_AW-1:0]     sram_addr_a, sram_addr_b;
    logic [SRAM_DW-1:0]     sram_dout_a, sram_dout_b;
    logic                   gfx_cs, gfx_ok, line_done;
    logic [TILE_W-1:0]      gfx_tile;
    logic [GFX_OFFS_W-1:0]  gfx_offs;
    logic [GFX_DW-1:0]      gfx_data;
    logic [OBJ_PIXEL_W-1:0] obj_pixel;

    logic [SRAM_DW-1:0]     sram [SRAM_WORDS];
    logic [GFX_DW-1:0]      gfx_mem [GFX_DEPTH];
    logic [OBJ_PIXEL_W-1:0] exp_line [SCREEN_W];
    integer                 seed;
    int                     gfx_wait = -1;
    logic                   gfx_seen = 1'b0;  // any request during the line
    int                     errors = 0, checks = 0, tests = 0, mark = 0;

    obj_engine u_obj_engine (
        .clk96_i       (clk96),
        .reset96_i     (reset96),
        .line_start_i  (line_start),
        .vrender_i     (vrender),
        .scroll_x_i    (scroll_x),
        .scroll_y_i    (scroll_y),
        .sram_addr_a_o (sram_addr_a),
        .sram_dout_a_i (sram_dout_a),
        .sram_addr_b_o (sram_addr_b),
        .sram_dout_b_i (sram_dout_b),
        .gfx_cs_o      (gfx_cs),
        .gfx_ok_i      (gfx_ok),
        .gfx_tile_o    (gfx_tile),
        .gfx_offs_o    (gfx_offs),
        .gfx_data_i    (gfx_data),
        .line_done_o   (line_done),
        .pix_addr_i    (pix_addr),
        .obj_pixel_o   (obj_pixel)
    );

    always #5 clk96 = ~clk96;

    always @(posedge clk96) begin  // one cycle read latency
        sram_dout_a <= sram[sram_addr_a % SRAM_WORDS];
        sram_dout_b <= sram[sram_addr_b % SRAM_WORDS];
    end

    // ack after 1 to 4 cycles with the data valid alongside
    always @(posedge clk96) begin
        if (gfx_cs) gfx_seen = 1'b1;
        if (gfx_ok) begin
            gfx_ok <= 1'b0;
        end else if (gfx_cs) begin
            if (gfx_wait < 0) gfx_wait = $random(seed) & 3;
            if (gfx_wait == 0) begin
                gfx_ok   <= 1'b1;
                gfx_data <= gfx_mem[int'(gfx_tile) + int'(gfx_offs)];
            end
            gfx_wait = gfx_wait - 1;
        end
    end

    function automatic int wrapped_pos(input int raw, input int scroll);
        int sum;
        sum = (raw + scroll) % 512;
        if (sum > WRAP_LIMIT) sum = sum - 512;
        return sum;
    endfunction

    // ascending priority, then entry order, so later draws overwrite earlier ones
    task automatic build_expected(input int vr, input int sx, input int sy);
        logic [ATTR_W-1:0] rec;
        logic [GFX_DW-1:0] data;
        int y, x, row, xs, offs, pos, code;
        for (int i = 0; i < SCREEN_W; i++) exp_line[i] = '0;
        for (int p = 0; p < NUM_PRI; p++) begin
            for (int e = 0; e < NUM_SPRITES; e++) begin
                rec = {sram[4*e], sram[4*e+1], sram[4*e+2], sram[4*e+3]};
                y   = wrapped_pos(int'(rec[ATTR_YPOS_LSB +: POS_W-1]), sy);
                row = vr - y;
                if (rec[ATTR_ACTIVE] && int'(rec[ATTR_PRI_LSB +: PRI_W]) == p && row >= 0
                    && row < 8 * (int'(rec[ATTR_YSIZE_LSB +: SIZE_W]) + 1)) begin
                    xs = int'(rec[ATTR_XSIZE_LSB +: SIZE_W]) + 1;
                    x  = wrapped_pos(int'(rec[ATTR_XPOS_LSB +: POS_W-1]), sx);
                    for (int c = 0; c < xs; c++) begin
                        offs = ((row / 8) * xs + c) * 8 + row % 8;
                        data = gfx_mem[int'(rec[ATTR_TILE_LSB +: TILE_W]) + offs];
                        for (int k = 0; k < SLICE_PIX; k++) begin
                            code = int'(data[4*k +: CODE_W]);
                            pos  = rec[ATTR_XFLIP] ? x + 8*xs - 1 - 8*c - k : x + 8*c + k;
                            if (code != 0 && pos >= 0 && pos < SCREEN_W)
                                exp_line[pos] = {rec[ATTR_PRI_LSB +: PRI_W],
                                                 rec[ATTR_PAL_LSB +: PAL_W], CODE_W'(code)};
                        end
                    end
                end
            end
        end
    endtask

    task automatic write_entry(input int idx, input bit act, input bit flip, input int pri,
                               input int pal, input int tile, input int xraw,
                               input int xsize, input int yraw, input int ysize);
        logic [ATTR_W-1:0] rec;
        rec = {$random(seed), $random(seed)};  // unused bits carry junk
        rec[ATTR_ACTIVE]                = act;
        rec[ATTR_XFLIP]                 = flip;
        rec[ATTR_PRI_LSB +: PRI_W]      = PRI_W'(pri);
        rec[ATTR_PAL_LSB +: PAL_W]      = PAL_W'(pal);
        rec[ATTR_TILE_LSB +: TILE_W]    = TILE_W'(tile);
        rec[ATTR_XPOS_LSB +: POS_W-1]   = (POS_W-1)'(xraw);
        rec[ATTR_XSIZE_LSB +: SIZE_W]   = SIZE_W'(xsize);
        rec[ATTR_YPOS_LSB +: POS_W-1]   = (POS_W-1)'(yraw);
        rec[ATTR_YSIZE_LSB +: SIZE_W]   = SIZE_W'(ysize);
        for (int w = 0; w < 4; w++) sram[4*idx + w] = rec[ATTR_W-1 - SRAM_DW*w -: SRAM_DW];
    endtask

    task automatic clear_table();
        for (int e = 0; e < NUM_SPRITES; e++) begin
            for (int w = 0; w < 4; w++) sram[4*e + w] = SRAM_DW'($random(seed));
            sram[4*e][SRAM_DW-1] = 1'b0;  // inactive with junk in the other bits
        end
    endtask

    task automatic random_table(input int vr, input int sy, input bit hit,
                                input int pri_mask, input int xsize_mask);
        int ysize, yraw;
        for (int e = 0; e < NUM_SPRITES; e++) begin
            ysize = $random(seed) & 15;
            yraw  = $random(seed) & 511;
            if (hit) yraw = (vr - (yraw % (8 * (ysize + 1))) - sy) & 511;  // lands on vr
            write_entry(e, ($random(seed) & 3) != 0, $random(seed) & 1,
                        $random(seed) & pri_mask, $random(seed) & 63,
                        $random(seed) & 32767, $random(seed) & 511,
                        $random(seed) & xsize_mask, yraw, ysize);
        end
    endtask

    task automatic check_pixel(input int addr, input logic [OBJ_PIXEL_W-1:0] got,
                               input logic [OBJ_PIXEL_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL obj_pixel_o[%0d] got %h expected %h", addr, got, exp);
        end
    endtask

    task automatic check_done(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // readout has one cycle in the DUT plus one for the address register
    task automatic read_line();
        for (int a = 0; a < SCREEN_W + 2; a++) begin
            @(posedge clk96);
            if (a >= 2) check_pixel(a - 2, obj_pixel, exp_line[a - 2]);
            if (a < SCREEN_W) pix_addr <= (POS_W-1)'(a);
        end
    endtask

    task automatic run_line(input int vr, input int sx, input int sy, input bit no_gfx);
        build_expected(vr, sx, sy);
        gfx_seen = 1'b0;
        @(posedge clk96);
        vrender    <= (POS_W-1)'(vr);
        scroll_x   <= (POS_W-1)'(sx);
        scroll_y   <= (POS_W-1)'(sy);
        line_start <= 1'b1;
        @(posedge clk96);
        line_start <= 1'b0;
        while (line_done !== 1'b1) @(posedge clk96);
        @(posedge clk96);
        check_done("line_done_o", line_done, 1'b0);  // single cycle strobe
        check_done("gfx_cs_o", gfx_cs, 1'b0);
        if (no_gfx) check_done("gfx_cs_o", gfx_seen, 1'b0);
        read_line();
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - mark);
        mark = errors;
    endtask

    initial begin
        #(NUM_LINES * LINE_CYCLES * 10);
        $display("timeout: a line did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed        = 32'hce9d;
        clk96       = 1'b0;
        reset96     = 1'b1;
        line_start  = 1'b0;
        vrender     = '0;
        scroll_x    = '0;
        scroll_y    = '0;
        pix_addr    = '0;
        sram_dout_a = '0;
        sram_dout_b = '0;
        gfx_ok      = 1'b0;
        gfx_data    = '0;
        for (int i = 0; i < GFX_DEPTH; i++) gfx_mem[i] = $random(seed) & $random(seed);
        clear_table();
        repeat (5) @(posedge clk96);
        reset96 <= 1'b0;

        @(posedge clk96);
        check_done("gfx_cs_o", gfx_cs, 1'b0);
        check_done("line_done_o", line_done, 1'b0);
        for (int i = 0; i < SCREEN_W; i++) exp_line[i] = '0;
        repeat (SCREEN_W) @(posedge clk96);  // buffer clear after reset
        read_line();
        finish_test("reset");

        write_entry(5, 1, 0, 2, 9, 100, 40, 2, 90, 1);  // row 10 lies in the second tile row
        run_line(100, 0, 0, 0);
        finish_test("single sprite");

        clear_table();
        write_entry(10, 1, 1, 3, 17, 2000, 400, 15, 60, 1);  // wraps to -112
        write_entry(20, 1, 1, 3, 33, 5000, 300, 3, 64, 0);   // crosses 320
        write_entry(30, 1, 1, 5, 40, 9000, 150, 1, 450, 15); // y wraps to -62
        run_line(65, 0, 0, 0);
        run_line(65, 200, 0, 0);
        finish_test("flip and clip");

        random_table(120, 0, 1, 3, 3);
        run_line(120, 0, 0, 0);
        finish_test("priority overlap");

        clear_table();
        write_entry(3, 1, 0, 2, 5, 100, 50, 0, 200, 0);
        write_entry(7, 0, 0, 1, 3, 10, 20, 3, 40, 3);  // inactive but on the line
        write_entry(9, 1, 1, 4, 8, 300, 60, 1, 10, 0);
        run_line(50, 0, 0, 1);
        finish_test("empty line");

        for (int l = 0; l < RAND_LINES; l++) begin
            int vr, sx, sy;
            vr = $random(seed) & 255;
            sx = $random(seed) & 511;
            sy = $random(seed) & 511;
            random_table(vr, sy, l[0], 15, 15);
            run_line(vr, sx, sy, 0);
        end
        finish_test("random lines");

        errors = errors + u_obj_engine.u_sva.assert_errs;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
endmodule
